// File: sim.f
logic/gen_pkg.sv
logic/gen_regs.sv
logic/gen_fsm.sv
logic/gen_ptr.sv
logic/gen_table.sv
logic/gen_lin.sv
logic/gen_top.sv
verification/gen_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -Wno-fatal --timescale 1ns/100ps
TOP       := gen_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
LOG       := sim.log

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || (echo "simulation ended without result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/gen_tb.sv
// testbench for the waveform generator channel
// loads the table over the bus, checks register readback, then plays a
// table of generator setups and compares every sample with a model
module gen_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int tbl_aw    = 10;
  localparam int frac_w    = 16;
  localparam int smp_w     = 14;
  localparam int tbl_words = 64;
  localparam int smp_max   = 2 ** (smp_w - 1) - 1;
  localparam int smp_min   = -(2 ** (smp_w - 1));
  localparam logic [12:0] tbl_base = 13'h1000;
  localparam logic [12:0] ctl_a    = 13'(gen_pkg::reg_ctl);
  // ctl strobe bits
  localparam logic [31:0] ctl_rst = 32'h1;
  localparam logic [31:0] ctl_str = 32'h2;
  localparam logic [31:0] ctl_stp = 32'h4;
  localparam logic [31:0] ctl_swt = 32'h8;

  typedef struct packed {
    logic [1:0]  mode;
    logic [31:0] siz;
    logic [31:0] off;
    logic [31:0] ste;
    logic [15:0] bdl;
    logic [15:0] bpl;
    logic [15:0] bpn;
    int          mul;
    int          sum;
    logic        rdy;
    logic        ext;
    int          cnt;
  } row_t;

  localparam int n_rows = 6;
  // mode {inf,ben}, siz, off, ste, bdl, bpl, bpn
  // then mul, sum, random ready, external trigger, sample count
  localparam row_t rows [n_rows] = '{
    '{2'b00, 32'h0014_0000, 32'h0003_8000, 32'h0001_8000, 16'd0, 16'd0, 16'd0,
      4096, 0, 1'b0, 1'b0, 60},
    '{2'b01, 32'h0000_0000, 32'h0002_0000, 32'h0001_4000, 16'd10, 16'd16, 16'd3,
      4096, 300, 1'b1, 1'b0, 48},
    '{2'b00, 32'h0040_0000, 32'h0000_0000, 32'h0001_0000, 16'd0, 16'd0, 16'd0,
      8191, 6000, 1'b0, 1'b0, 64},
    '{2'b00, 32'h0040_0000, 32'h0000_8000, 32'h0001_0000, 16'd0, 16'd0, 16'd0,
      -8192, -6000, 1'b0, 1'b0, 64},
    '{2'b00, 32'h0025_4000, 32'h0000_2000, 32'h0002_3000, 16'd0, 16'd0, 16'd0,
      3000, -500, 1'b1, 1'b0, 80},
    '{2'b00, 32'h0010_0000, 32'h0005_0000, 32'h0001_0000, 16'd0, 16'd0, 16'd0,
      4096, 100, 1'b0, 1'b1, 24}
  };

  // writable registers and readback values
  localparam int n_regs = 11;
  localparam gen_pkg::reg_addr_e reg_list [n_regs] = '{
    gen_pkg::reg_trg_mask, gen_pkg::reg_mode, gen_pkg::reg_siz, gen_pkg::reg_off,
    gen_pkg::reg_ste, gen_pkg::reg_bdl, gen_pkg::reg_bpl, gen_pkg::reg_bpn,
    gen_pkg::reg_mul, gen_pkg::reg_sum, gen_pkg::reg_ena
  };
  localparam logic [31:0] reg_val [n_regs] = '{
    32'h1, 32'h3, 32'h0123_4567, 32'h0002_8000, 32'h0000_c000, 32'h1234,
    32'habcd, 32'h0042, 32'h0000_1abc, 32'hffff_ff00, 32'h1
  };

  logic                    bus;
  logic                    arst_n;
  gen_pkg::bus_req_t       req;
  gen_pkg::bus_rsp_t       rsp;
  logic                    trg;
  logic signed [smp_w-1:0] smp_data;
  logic                    smp_valid;
  logic                    smp_ready;
  logic                    evn_per;
  logic                    evn_lst;
  logic                    irq;

  logic [31:0] lfsr = 32'h2e5b;
  int          tbl_val [tbl_words];
  int          n_per;
  int          n_lst;
  int          n_irq;
  int          cycles = 0;
  int          limit;

  gen_top #(.tbl_aw(tbl_aw), .frac_w(frac_w), .smp_w(smp_w)) u_dut (
    .bus, .arst_n, .req, .rsp, .trg, .smp_data, .smp_valid, .smp_ready,
    .evn_per, .evn_lst, .irq
  );

  initial begin
    bus = 1'b0;
    forever #4 bus = ~bus;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  // galois lfsr, taps for x^32+x^22+x^2+x+1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per bit
  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    repeat (n) begin
      lfsr = lfsr_next(lfsr);
      v = (v << 1) | int'(lfsr[0]);
    end
    return v;
  endfunction

  function automatic int timeout_limit();
    int total;
    total = 0;
    for (int i = 0; i < n_rows; i++) total += rows[i].cnt;
    return total * 4 + 200;
  endfunction

  function automatic int clamp_smp(input int v);
    if (v > smp_max) return smp_max;
    if (v < smp_min) return smp_min;
    return v;
  endfunction

  // expected k-th sample of a row
  function automatic int expected_sample(input row_t r, input int k);
    longint p;
    int     j;
    int     x;
    int     y;
    if (r.mode[0]) begin
      // burst, pointer restarts at off every period, no wrap
      j = k % int'(r.bpl);
      p = longint'(r.off) + longint'(j) * longint'(r.ste);
      x = (j >= int'(r.bdl)) ? 0 : tbl_val[p >> frac_w];
    end else begin
      p = longint'(r.off);
      repeat (k) begin
        p = p + longint'(r.ste);
        if (p >= longint'(r.siz)) p = p - longint'(r.siz);
      end
      x = tbl_val[p >> frac_w];
    end
    // mul of 4096 is unity
    y = clamp_smp((x * r.mul) >>> (smp_w - 2));
    return clamp_smp(y + r.sum);
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  task automatic next_cycle();
    @(posedge bus);
    #1;
  endtask

  task automatic wait_ack(output logic [31:0] d);
    @(negedge bus);
    while (!rsp.ack) @(negedge bus);
    d = rsp.rdata;
    next_cycle();
  endtask

  task automatic bus_write(input logic [12:0] a, input logic [31:0] d);
    logic [31:0] unused;
    req.wen   = 1'b1;
    req.addr  = a;
    req.wdata = d;
    next_cycle();
    req.wen = 1'b0;
    wait_ack(unused);
  endtask

  task automatic bus_read(input logic [12:0] a, output logic [31:0] d);
    req.ren  = 1'b1;
    req.addr = a;
    next_cycle();
    req.ren = 1'b0;
    wait_ack(d);
  endtask

  task automatic count_events();
    if (evn_per) n_per++;
    if (evn_lst) n_lst++;
    if (irq) n_irq++;
  endtask

  // stream must stay empty
  task automatic watch_idle(input int n);
    repeat (n) begin
      @(negedge bus);
      count_events();
      check("smp_valid", 32'(smp_valid), 32'h0);
      next_cycle();
    end
  endtask

  task automatic pulse_trg();
    trg = 1'b1;
    next_cycle();
    trg = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test steps
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_regs();
    logic [31:0] rd;
    bus_read(ctl_a, rd);
    check("ctl", rd, 32'(gen_pkg::st_idle));
    for (int i = 0; i < n_regs; i++) bus_write(13'(reg_list[i]), reg_val[i]);
    for (int i = 0; i < n_regs; i++) begin
      bus_read(13'(reg_list[i]), rd);
      check(reg_list[i].name(), rd, reg_val[i]);
    end
  endtask

  task automatic load_table();
    logic [31:0] rd;
    for (int i = 0; i < tbl_words; i++) begin
      // ramp across the signed range, a few random low bits
      tbl_val[i] = i * 250 - 8000 + rand_bits(5);
      bus_write(tbl_base | 13'(i << 2), 32'(tbl_val[i]));
    end
    bus_read(tbl_base, rd);
    check("tbl_rdata", rd, 32'(tbl_val[0]));
    bus_read(tbl_base | 13'((tbl_words - 1) << 2), rd);
    check("tbl_rdata", rd, 32'(tbl_val[tbl_words-1]));
  endtask

  task automatic configure(input row_t r);
    bus_write(ctl_a, ctl_rst);
    bus_write(13'(gen_pkg::reg_trg_mask), 32'h0);
    bus_write(13'(gen_pkg::reg_mode), 32'(r.mode));
    bus_write(13'(gen_pkg::reg_siz), r.siz);
    bus_write(13'(gen_pkg::reg_off), r.off);
    bus_write(13'(gen_pkg::reg_ste), r.ste);
    bus_write(13'(gen_pkg::reg_bdl), 32'(r.bdl));
    bus_write(13'(gen_pkg::reg_bpl), 32'(r.bpl));
    bus_write(13'(gen_pkg::reg_bpn), 32'(r.bpn));
    bus_write(13'(gen_pkg::reg_mul), 32'(r.mul));
    bus_write(13'(gen_pkg::reg_sum), 32'(r.sum));
    bus_write(13'(gen_pkg::reg_ena), 32'h1);
  endtask

  // takes samples on valid and ready, in order
  task automatic collect_samples(input row_t r);
    int got;
    got = 0;
    while (got < r.cnt) begin
      smp_ready = r.rdy ? 1'(rand_bits(1)) : 1'b1;
      @(negedge bus);
      count_events();
      if (smp_valid && smp_ready) begin
        check("smp_data", 32'(smp_data), 32'(expected_sample(r, got)));
        got++;
      end
      next_cycle();
    end
    smp_ready = 1'b1;
  endtask

  task automatic run_row(input row_t r);
    logic [31:0] rd;
    n_per = 0;
    n_lst = 0;
    n_irq = 0;
    configure(r);
    bus_write(ctl_a, ctl_str);
    if (r.ext) begin
      // masked trigger must leave the generator armed
      pulse_trg();
      watch_idle(8);
      bus_read(ctl_a, rd);
      check("ctl", rd, 32'(gen_pkg::st_armed));
      bus_write(13'(gen_pkg::reg_trg_mask), 32'h1);
      pulse_trg();
    end else begin
      bus_write(ctl_a, ctl_swt);
    end
    collect_samples(r);
    if (r.mode[0]) begin
      // burst ends itself, nothing beyond bpn periods
      watch_idle(6);
      check("evn_per count", n_per, 32'(r.bpn));
      check("evn_lst count", n_lst, 32'h1);
      check("irq count", n_irq, 32'h1);
      bus_read(ctl_a, rd);
      check("ctl", rd, 32'(gen_pkg::st_idle));
    end else begin
      // stop, then pipeline drains
      bus_write(ctl_a, ctl_stp);
      repeat (2) next_cycle();
      watch_idle(4);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence and timeout
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge bus) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("run timed out after %0d cycles", cycles);
      $display("=== FAIL ===");
      $fatal(1);
    end
  end

  initial begin
    req       = '0;
    trg       = 1'b0;
    smp_ready = 1'b1;
    arst_n    = 1'b0;
    limit     = timeout_limit();
    repeat (3) @(posedge bus);
    #1;
    arst_n = 1'b1;
    check_regs();
    load_table();
    for (int i = 0; i < n_rows; i++) run_row(rows[i]);
    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: logic/gen_top.sv
// arbitrary waveform generator channel
// register block, state machine, read pointer, waveform table and
// gain/offset output stage
module gen_top #(
  parameter int tbl_aw = 10,
  parameter int frac_w = 16,
  parameter int smp_w  = 14
) (
  input  logic                    bus,
  input  logic                    arst_n,
  input  gen_pkg::bus_req_t       req,
  output gen_pkg::bus_rsp_t       rsp,
  input  logic                    trg,
  output logic signed [smp_w-1:0] smp_data,
  output logic                    smp_valid,
  input  logic                    smp_ready,
  output logic                    evn_per,
  output logic                    evn_lst,
  output logic                    irq
);

  // pointer must fit the cfg fields, table must fit below address bit 12
  if (gen_pkg::ptr_w(tbl_aw, frac_w) > gen_pkg::cw) begin : g_chk_ptr
    $error("pointer width exceeds cfg field width");
  end
  if (tbl_aw > gen_pkg::aw - 3 || smp_w > gen_pkg::dw) begin : g_chk_tbl
    $error("table depth or sample width out of range");
  end

  gen_pkg::ctl_t           ctl;
  gen_pkg::cfg_t           cfg;
  gen_pkg::gen_state_e     state;
  logic signed [smp_w-1:0] mul;
  logic signed [smp_w-1:0] sum;
  logic                    ena;
  logic                    trg_mask;
  logic [15:0]             sts_bpl;
  logic [15:0]             sts_bpn;
  logic                    tbl_we;
  logic [tbl_aw-1:0]       tbl_addr;
  logic [smp_w-1:0]        tbl_wdata;
  logic [smp_w-1:0]        tbl_rdata;
  logic                    run;
  logic                    ptr_load;
  logic                    adv;
  logic [tbl_aw-1:0]       tbl_raddr;
  logic                    smp_zero;
  logic signed [smp_w-1:0] smp;
  logic                    zero;

  gen_regs #(.tbl_aw(tbl_aw), .smp_w(smp_w)) u_regs (
    .bus, .arst_n, .req, .rsp, .ctl, .cfg, .mul, .sum, .ena, .trg_mask,
    .state, .sts_bpl, .sts_bpn, .evn_lst, .irq,
    .tbl_we, .tbl_addr, .tbl_wdata, .tbl_rdata
  );

  gen_fsm u_fsm (
    .bus, .arst_n, .ctl, .trg, .trg_mask, .evn_lst, .state, .run, .ptr_load
  );

  gen_ptr #(.tbl_aw(tbl_aw), .frac_w(frac_w)) u_ptr (
    .bus, .arst_n, .cfg, .run, .ptr_load, .adv, .tbl_raddr, .smp_zero,
    .evn_per, .evn_lst, .sts_bpl, .sts_bpn
  );

  gen_table #(.tbl_aw(tbl_aw), .smp_w(smp_w)) u_table (
    .bus, .tbl_we, .tbl_addr, .tbl_wdata, .tbl_rdata,
    .raddr(tbl_raddr), .adv, .zero_in(smp_zero), .smp, .zero_out(zero)
  );

  gen_lin #(.smp_w(smp_w)) u_lin (
    .bus, .arst_n, .smp, .zero, .run, .mul, .sum, .ena,
    .smp_data, .smp_valid, .smp_ready, .adv
  );

endmodule

// File: logic/gen_lin.sv
// gain and offset stage
// scales each sample, adds the offset with saturation and holds the
// result in the output stream register, which sets the stall for all
module gen_lin #(
  parameter int smp_w = 14
) (
  input  logic                    bus,
  input  logic                    arst_n,
  input  logic signed [smp_w-1:0] smp,
  input  logic                    zero,
  input  logic                    run,
  input  logic signed [smp_w-1:0] mul,
  input  logic signed [smp_w-1:0] sum,
  input  logic                    ena,
  output logic signed [smp_w-1:0] smp_data,
  output logic                    smp_valid,
  input  logic                    smp_ready,
  output logic                    adv
);

  localparam int pw = 2 * smp_w;
  // signed range limits, extended to product width
  localparam logic signed [pw-1:0] vmax = (pw'(1) <<< (smp_w - 1)) - 1;
  localparam logic signed [pw-1:0] vmin = -(pw'(1) <<< (smp_w - 1));

  logic signed [smp_w-1:0] x;
  logic signed [smp_w-1:0] scl;
  logic signed [smp_w-1:0] res;
  logic signed [pw-1:0]    prod;
  logic signed [pw-1:0]    acc;
  logic                    vld_tbl;
  logic                    vld_out;

  function automatic logic signed [smp_w-1:0] sat(input logic signed [pw-1:0] v);
    if (v > vmax) return vmax[smp_w-1:0];
    else if (v < vmin) return vmin[smp_w-1:0];
    else return v[smp_w-1:0];
  endfunction

  // gap samples count as zero
  assign x = zero ? '0 : smp;

  // mul of 2^(smp_w-2) is unity gain
  assign prod = x * mul;
  assign scl  = sat(prod >>> (smp_w - 2));
  assign acc  = scl + sum;
  assign res  = sat(acc);

  // stall only on a presented sample that is not taken
  assign smp_valid = vld_out & ena;
  assign adv       = ~smp_valid | smp_ready;

  // valid pipe, table stage then output stage
  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      vld_tbl <= 1'b0;
      vld_out <= 1'b0;
    end else if (adv) begin
      vld_tbl <= run;
      vld_out <= vld_tbl;
    end
  end

  always_ff @(posedge bus) begin
    if (adv && vld_tbl) smp_data <= res;
  end

  a_data_hold: assert property (@(posedge bus) disable iff (!arst_n)
    (smp_valid && !smp_ready) |=> $stable(smp_data));

endmodule

// File: logic/gen_table.sv
// waveform table
// dual port ram, cpu write/read port and a stallable generator read port
// with the gap flag carried alongside the sample
module gen_table #(
  parameter int tbl_aw = 10,
  parameter int smp_w  = 14
) (
  input  logic                    bus,
  input  logic                    tbl_we,
  input  logic [tbl_aw-1:0]       tbl_addr,
  input  logic [smp_w-1:0]        tbl_wdata,
  output logic [smp_w-1:0]        tbl_rdata,
  input  logic [tbl_aw-1:0]       raddr,
  input  logic                    adv,
  input  logic                    zero_in,
  output logic signed [smp_w-1:0] smp,
  output logic                    zero_out
);

  logic [smp_w-1:0] mem [2**tbl_aw];

  // cpu port, read first
  always_ff @(posedge bus) begin
    if (tbl_we) begin
      mem[tbl_addr] <= tbl_wdata;
    end
    tbl_rdata <= mem[tbl_addr];
  end

  // generator port
  // holds sample and flag while the stream stalls
  always_ff @(posedge bus) begin
    if (adv) begin
      smp      <= mem[raddr];
      zero_out <= zero_in;
    end
  end

endmodule

// File: logic/gen_ptr.sv
// table read pointer
// fixed point phase accumulator with wrap in continuous mode, burst step
// and period counters, gap flag and per-period / last-period events
module gen_ptr #(
  parameter int tbl_aw = 10,
  parameter int frac_w = 16
) (
  input  logic              bus,
  input  logic              arst_n,
  input  gen_pkg::cfg_t     cfg,
  input  logic              run,
  input  logic              ptr_load,
  input  logic              adv,
  output logic [tbl_aw-1:0] tbl_raddr,
  output logic              smp_zero,
  output logic              evn_per,
  output logic              evn_lst,
  output logic [15:0]       sts_bpl,
  output logic [15:0]       sts_bpn
);

  localparam int cw = gen_pkg::cw;

  logic [cw-1:0] ptr;
  logic [cw:0]   ptr_sum;
  logic [cw:0]   ptr_sub;
  logic [cw-1:0] ptr_nxt;
  logic [15:0]   bcnt;
  logic [15:0]   pcnt;
  logic          first;
  logic          step;
  logic          wrap;
  logic          per_end;
  logic          per_lst;

  // one table read per advancing run cycle
  assign step = run & adv;

  // accumulate with a carry bit, wrap only in continuous mode
  assign ptr_sum = ptr + cfg.ste;
  assign ptr_sub = ptr_sum - {1'b0, cfg.siz};
  assign wrap    = ~cfg.ben && (ptr_sum >= {1'b0, cfg.siz});
  assign ptr_nxt = wrap ? ptr_sub[cw-1:0] : ptr_sum[cw-1:0];

  // burst period boundaries
  assign per_end = cfg.ben && (bcnt == cfg.bpl - 16'd1);
  assign per_lst = per_end && ~cfg.inf && (pcnt == cfg.bpn - 16'd1);

  ////////////////////////////////////////////////////////////////////////////
  // pointer and counters
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      ptr   <= '0;
      bcnt  <= '0;
      pcnt  <= '0;
      first <= 1'b0;
    end else if (ptr_load) begin
      ptr   <= cfg.off;
      bcnt  <= '0;
      pcnt  <= '0;
      first <= 1'b1;
    end else if (step) begin
      // next step opens a new period
      first <= wrap | per_end;
      if (per_end) begin
        ptr  <= cfg.off;
        bcnt <= '0;
        pcnt <= pcnt + 16'd1;
      end else begin
        ptr <= ptr_nxt;
        if (cfg.ben) bcnt <= bcnt + 16'd1;
      end
    end
  end

  // integer part addresses the table
  assign tbl_raddr = ptr[frac_w +: tbl_aw];

  // steps past the data length play silence
  assign smp_zero = cfg.ben && (bcnt >= cfg.bdl);

  assign evn_per = step & first;
  assign evn_lst = step & per_lst;
  assign sts_bpl = bcnt;
  assign sts_bpn = pcnt;

  a_ptr_range: assert property (@(posedge bus) disable iff (!arst_n)
    (run && !cfg.ben && cfg.siz != '0) |-> ptr < cfg.siz);

endmodule

// File: logic/gen_fsm.sv
// generator state machine
// idle, armed on start, running on software or masked external trigger;
// back to idle on stop, reset or the last burst step
module gen_fsm (
  input  logic                bus,
  input  logic                arst_n,
  input  gen_pkg::ctl_t       ctl,
  input  logic                trg,
  input  logic                trg_mask,
  input  logic                evn_lst,
  output gen_pkg::gen_state_e state,
  output logic                run,
  output logic                ptr_load
);

  gen_pkg::gen_state_e state_nxt;
  logic                fire;

  // trigger sources
  assign fire = ctl.swt | (trg & trg_mask);

  always_comb begin
    state_nxt = state;
    case (state)
      gen_pkg::st_idle: begin
        if (ctl.str) state_nxt = gen_pkg::st_armed;
      end
      gen_pkg::st_armed: begin
        if (fire) state_nxt = gen_pkg::st_run;
      end
      gen_pkg::st_run: begin
        // last step of last period ends the run
        if (evn_lst) state_nxt = gen_pkg::st_idle;
      end
      default: state_nxt = gen_pkg::st_idle;
    endcase
    // stop and reset win over everything
    if (ctl.rst || ctl.stp) state_nxt = gen_pkg::st_idle;
  end

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      state <= gen_pkg::st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  assign run = (state == gen_pkg::st_run);

  // pointer preset in the transition cycle
  assign ptr_load = (state == gen_pkg::st_armed) && (state_nxt == gen_pkg::st_run);

  // load pulses exactly on entry into run
  a_load_entry: assert property (@(posedge bus) disable iff (!arst_n)
    $past(ptr_load) == $rose(run));

endmodule

// File: logic/gen_regs.sv
// generator register block
// decodes the cpu bus into config registers and ctl strobes, forwards
// table accesses, muxes read data and registers the interrupt
module gen_regs #(
  parameter int tbl_aw = 10,
  parameter int smp_w  = 14
) (
  input  logic                    bus,
  input  logic                    arst_n,
  input  gen_pkg::bus_req_t       req,
  output gen_pkg::bus_rsp_t       rsp,
  output gen_pkg::ctl_t           ctl,
  output gen_pkg::cfg_t           cfg,
  output logic signed [smp_w-1:0] mul,
  output logic signed [smp_w-1:0] sum,
  output logic                    ena,
  output logic                    trg_mask,
  input  gen_pkg::gen_state_e     state,
  input  logic [15:0]             sts_bpl,
  input  logic [15:0]             sts_bpn,
  input  logic                    evn_lst,
  output logic                    irq,
  output logic                    tbl_we,
  output logic [tbl_aw-1:0]       tbl_addr,
  output logic [smp_w-1:0]        tbl_wdata,
  input  logic [smp_w-1:0]        tbl_rdata
);

  localparam int dw = gen_pkg::dw;
  localparam int cw = gen_pkg::cw;

  logic               tbl_sel;
  logic               reg_we;
  gen_pkg::reg_addr_e ofs;
  logic               ack_q;
  logic               tbl_rd_q;
  logic [dw-1:0]      rdata_q;

  // top address bit picks the table, low 7 bits the register
  assign tbl_sel = req.addr[gen_pkg::aw-1];
  assign reg_we  = req.wen & ~tbl_sel;
  assign ofs     = gen_pkg::reg_addr_e'(req.addr[6:0]);

  // table port, word addressed
  assign tbl_we    = req.wen & tbl_sel;
  assign tbl_addr  = req.addr[2 +: tbl_aw];
  assign tbl_wdata = req.wdata[smp_w-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // handshake, strobes, interrupt
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      ack_q    <= 1'b0;
      tbl_rd_q <= 1'b0;
      ctl      <= '0;
      irq      <= 1'b0;
    end else begin
      ack_q    <= req.wen | req.ren;
      tbl_rd_q <= req.ren & tbl_sel;
      // one-cycle pulses, cleared unless ctl is written
      ctl      <= (reg_we && ofs == gen_pkg::reg_ctl) ? gen_pkg::ctl_t'(req.wdata[3:0]) : '0;
      irq      <= evn_lst;
    end
  end

  // config writes
  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      cfg      <= '0;
      mul      <= '0;
      sum      <= '0;
      ena      <= 1'b0;
      trg_mask <= 1'b0;
    end else if (reg_we) begin
      case (ofs)
        gen_pkg::reg_trg_mask: trg_mask <= req.wdata[0];
        gen_pkg::reg_mode: begin
          cfg.ben <= req.wdata[0];
          cfg.inf <= req.wdata[1];
        end
        gen_pkg::reg_siz: cfg.siz <= req.wdata[cw-1:0];
        gen_pkg::reg_off: cfg.off <= req.wdata[cw-1:0];
        gen_pkg::reg_ste: cfg.ste <= req.wdata[cw-1:0];
        gen_pkg::reg_bdl: cfg.bdl <= req.wdata[15:0];
        gen_pkg::reg_bpl: cfg.bpl <= req.wdata[15:0];
        gen_pkg::reg_bpn: cfg.bpn <= req.wdata[15:0];
        gen_pkg::reg_mul: mul     <= req.wdata[smp_w-1:0];
        gen_pkg::reg_sum: sum     <= req.wdata[smp_w-1:0];
        gen_pkg::reg_ena: ena     <= req.wdata[0];
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // readback
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (req.ren) begin
      case (ofs)
        gen_pkg::reg_ctl:      rdata_q <= dw'(state);
        gen_pkg::reg_trg_mask: rdata_q <= dw'(trg_mask);
        gen_pkg::reg_mode:     rdata_q <= dw'({cfg.inf, cfg.ben});
        gen_pkg::reg_siz:      rdata_q <= dw'(cfg.siz);
        gen_pkg::reg_off:      rdata_q <= dw'(cfg.off);
        gen_pkg::reg_ste:      rdata_q <= dw'(cfg.ste);
        gen_pkg::reg_bdl:      rdata_q <= dw'(cfg.bdl);
        gen_pkg::reg_bpl:      rdata_q <= dw'(cfg.bpl);
        gen_pkg::reg_bpn:      rdata_q <= dw'(cfg.bpn);
        gen_pkg::reg_sts_bpl:  rdata_q <= dw'(sts_bpl);
        gen_pkg::reg_sts_bpn:  rdata_q <= dw'(sts_bpn);
        // gain and offset read back sign extended
        gen_pkg::reg_mul:      rdata_q <= dw'(mul);
        gen_pkg::reg_sum:      rdata_q <= dw'(sum);
        gen_pkg::reg_ena:      rdata_q <= dw'(ena);
        default:               rdata_q <= 'x;
      endcase
    end
  end

  // table data arrives one cycle late, same as the register path
  assign rsp = {ack_q, tbl_rd_q ? dw'(signed'(tbl_rdata)) : rdata_q};

  a_ack_follows: assert property (@(posedge bus) disable iff (!arst_n)
    (req.wen || req.ren) |=> rsp.ack);
  a_ack_only: assert property (@(posedge bus) disable iff (!arst_n)
    rsp.ack |-> $past(req.wen || req.ren));

endmodule

// File: logic/gen_pkg.sv
// waveform generator shared definitions
// bus request/response, register map, generator states, control strobes
// and the configuration bundle handed to the pointer and state machine
package gen_pkg;

  // bus byte address and data widths, addr bit 12 selects the table
  localparam int aw = 13;
  localparam int dw = 32;

  // pointer width from table depth and fraction width
  function automatic int ptr_w(input int tbl_aw, input int frac_w);
    return tbl_aw + frac_w;
  endfunction

  // cfg field width, sized for the largest supported pointer
  localparam int cw = ptr_w(10, 16);

  typedef struct packed {
    logic          wen;
    logic          ren;
    logic [aw-1:0] addr;
    logic [dw-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic          ack;
    logic [dw-1:0] rdata;
  } bus_rsp_t;

  // register offsets, low 7 address bits
  typedef enum logic [6:0] {
    reg_ctl      = 7'h00,
    reg_trg_mask = 7'h08,
    reg_mode     = 7'h10,
    reg_siz      = 7'h14,
    reg_off      = 7'h18,
    reg_ste      = 7'h1c,
    reg_bdl      = 7'h24,
    reg_bpl      = 7'h28,
    reg_bpn      = 7'h2c,
    reg_sts_bpl  = 7'h30,
    reg_sts_bpn  = 7'h34,
    reg_mul      = 7'h40,
    reg_sum      = 7'h44,
    reg_ena      = 7'h48
  } reg_addr_e;

  // ctl write bits: bit0 rst, bit1 str, bit2 stp, bit3 swt
  typedef struct packed {
    logic swt;
    logic stp;
    logic str;
    logic rst;
  } ctl_t;

  typedef enum logic [1:0] {
    st_idle  = 2'd0,
    st_armed = 2'd1,
    st_run   = 2'd2
  } gen_state_e;

  typedef struct packed {
    logic          ben;
    logic          inf;
    logic [cw-1:0] siz;
    logic [cw-1:0] off;
    logic [cw-1:0] ste;
    logic [15:0]   bdl;
    logic [15:0]   bpl;
    logic [15:0]   bpn;
  } cfg_t;

endpackage
